// ==== src/rv_core_settings.svh ====
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// core-wide sizing for the RV32 subset

// data path and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// byte offset bits inside one data word
`define RV_OFS_W 2

// lanes per word follow from the width
// RV_XLEN / 8 lanes, each 8 bits wide

// RV_OFS_W must stay log2 of the lane count
// 4 lanes -> 2 offset bits

`endif

// ==== src/rv_core_pkg.sv ====
`include "rv_core_settings.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]          word_t;     // data or address word
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t; // register index
  typedef logic [`RV_XLEN/8-1:0]        strb_t;     // one bit per byte lane
  typedef logic [2:0]                   funct3_t;
  typedef logic [1:0]                   wb_sel_t;

  // writeback source select
  localparam wb_sel_t wb_adder = 2'd0;
  localparam wb_sel_t wb_link  = 2'd1; // pc + 4
  localparam wb_sel_t wb_load  = 2'd2;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_system = 7'b111_0011
  } opcode_e;

  // AXI4-Lite master sequencing
  typedef enum logic [1:0] {
    idle,
    addr,  // address and data handshakes
    wresp,
    rresp
  } lsu_state_e;

  typedef struct packed {
    logic    reg_wen;
    logic    a_sel_pc;  // adder takes pc instead of rs1
    wb_sel_t wb_sel;
    logic    jump;
    logic    mem_read;
    logic    mem_write;
    funct3_t funct3;
    logic    ebreak;
  } ctrl_t;

  // one data access as seen by the lsu
  typedef struct packed {
    logic    read;
    logic    write;
    funct3_t funct3;    // access size and sign
    word_t   addr;
    word_t   wdata;     // unshifted store value
  } mem_req_t;

endpackage

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::ctrl_t     ctrl,
  output rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::reg_addr_t rd,
  output rv_core_pkg::word_t     imm
);
  import rv_core_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_j;
  word_t   imm_u;
  logic    is_ebreak;

  // fixed field positions
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign rd     = inst[11:7];
  assign rs2    = inst[24:20];

  // lui reads x0 so the adder passes the immediate through
  assign rs1 = (opcode == op_lui) ? '0 : inst[19:15];

  // sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000}; // already shifted

  // imm=1, rs1=0, funct3=0, rd=0
  assign is_ebreak = (inst[31:7] == 25'h000_2000);

  always_comb begin
    ctrl        = '0; // unknown encodings retire as no-ops
    ctrl.funct3 = funct3;
    imm         = '0;
    case (opcode)
      op_imm: begin
        if (funct3 == 3'b000) begin // addi only
          ctrl.reg_wen = 1'b1;
          imm          = imm_i;
        end
      end
      op_lui: begin
        ctrl.reg_wen = 1'b1;
        imm          = imm_u;
      end
      op_auipc: begin
        ctrl.reg_wen  = 1'b1;
        ctrl.a_sel_pc = 1'b1;
        imm           = imm_u;
      end
      op_jal: begin
        ctrl.reg_wen  = 1'b1;
        ctrl.a_sel_pc = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.wb_sel   = wb_link;
        imm           = imm_j;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_wen = 1'b1;
          ctrl.jump    = 1'b1;
          ctrl.wb_sel  = wb_link;
          imm          = imm_i;
        end
      end
      op_load: begin
        // lb lh lw lbu lhu
        if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
          ctrl.reg_wen  = 1'b1;
          ctrl.mem_read = 1'b1;
          ctrl.wb_sel   = wb_load;
          imm           = imm_i;
        end
      end
      op_store: begin
        if (funct3 <= 3'b010) begin // sb sh sw
          ctrl.mem_write = 1'b1;
          imm            = imm_s;
        end
      end
      op_system: ctrl.ebreak = is_ebreak;
      default: ;
    endcase
  end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   wen,
  input  rv_core_pkg::reg_addr_t waddr,
  input  rv_core_pkg::word_t     wdata,
  input  rv_core_pkg::reg_addr_t rs1addr,
  input  rv_core_pkg::reg_addr_t rs2addr,
  output rv_core_pkg::word_t     rs1data,
  output rv_core_pkg::word_t     rs2data
);
  import rv_core_pkg::*;

  word_t regs [`RV_NREGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read ports
  assign rs1data = (rs1addr == '0) ? '0 : regs[rs1addr];
  assign rs2data = (rs2addr == '0) ? '0 : regs[rs2addr];

endmodule

// ==== src/rv_lsu.sv ====
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_lsu (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_core_pkg::mem_req_t req,
  output rv_core_pkg::word_t    load_data,
  output logic                  done,
  // write address
  output logic                  awvalid,
  input  logic                  awready,
  output rv_core_pkg::word_t    awaddr,
  // write data
  output logic                  wvalid,
  input  logic                  wready,
  output rv_core_pkg::word_t    wdata,
  output rv_core_pkg::strb_t    wstrb,
  // write response
  input  logic                  bvalid,
  output logic                  bready,
  // read address
  output logic                  arvalid,
  input  logic                  arready,
  output rv_core_pkg::word_t    araddr,
  // read data
  input  logic                  rvalid,
  output logic                  rready,
  input  rv_core_pkg::word_t    rdata
);
  import rv_core_pkg::*;

  lsu_state_e           state;
  lsu_state_e           state_next;
  logic                 aw_done;  // aw accepted in this access
  logic                 w_done;   // w accepted in this access
  logic                 aw_fin;
  logic                 w_fin;
  logic [`RV_OFS_W-1:0] ofs;
  word_t                lane;

  assign ofs = req.addr[`RV_OFS_W-1:0];

  // address and data channels may complete in either order
  assign aw_fin = aw_done | (awvalid & awready);
  assign w_fin  = w_done | (wvalid & wready);

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (req.read || req.write) state_next = addr;
      end
      addr: begin
        if (req.read) begin
          if (arready) state_next = rresp;
        end else if (aw_fin && w_fin) begin
          state_next = wresp;
        end
      end
      wresp: if (bvalid) state_next = idle;
      rresp: if (rvalid) state_next = idle;
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      state <= state_next;
      if (state_next == addr) begin
        aw_done <= aw_fin;
        w_done  <= w_fin;
      end else begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    end
  end

  // payload comes straight from the request, held by the stall
  assign awvalid = (state == addr) && req.write && !aw_done;
  assign wvalid  = (state == addr) && req.write && !w_done;
  assign arvalid = (state == addr) && req.read;
  assign awaddr  = req.addr;
  assign araddr  = req.addr;
  assign bready  = (state == wresp);
  assign rready  = (state == rresp);

  assign done = (state == wresp && bvalid) || (state == rresp && rvalid);

  // store lane placement
  assign wdata = req.wdata << {ofs, 3'b000};

  always_comb begin
    case (req.funct3)
      3'b000:  wstrb = strb_t'(1) << ofs;     // sb
      3'b001:  wstrb = strb_t'(2'b11) << ofs; // sh
      3'b010:  wstrb = '1;                    // sw
      default: wstrb = '0;
    endcase
  end

  // load lane extraction
  assign lane = rdata >> {ofs, 3'b000};

  always_comb begin
    case (req.funct3)
      3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};   // lb
      3'b001:  load_data = {{16{lane[15]}}, lane[15:0]}; // lh
      3'b100:  load_data = {24'h00_0000, lane[7:0]};     // lbu
      3'b101:  load_data = {16'h0000, lane[15:0]};       // lhu
      default: load_data = lane;                         // lw
    endcase
  end

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core_top (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_core_pkg::word_t inst,
  output rv_core_pkg::word_t pc,
  output logic               halt,
  // AXI4-Lite data master
  output logic               awvalid,
  input  logic               awready,
  output rv_core_pkg::word_t awaddr,
  output logic               wvalid,
  input  logic               wready,
  output rv_core_pkg::word_t wdata,
  output rv_core_pkg::strb_t wstrb,
  input  logic               bvalid,
  output logic               bready,
  output logic               arvalid,
  input  logic               arready,
  output rv_core_pkg::word_t araddr,
  input  logic               rvalid,
  output logic               rready,
  input  rv_core_pkg::word_t rdata
);
  import rv_core_pkg::*;

  ctrl_t     ctrl;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  word_t     rs1data;
  word_t     rs2data;
  word_t     adder_a;
  word_t     adder_out;
  word_t     pc_plus4;
  word_t     pc_next;
  word_t     wb_data;
  word_t     load_data;
  mem_req_t  req;
  logic      lsu_done;
  logic      stall;
  logic      retire;

  rv_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd),
    .imm  (imm)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .wen     (ctrl.reg_wen && retire),
    .waddr   (rd),
    .wdata   (wb_data),
    .rs1addr (rs1),
    .rs2addr (rs2),
    .rs1data (rs1data),
    .rs2data (rs2data)
  );

  // shared adder for addresses, targets and addi/lui/auipc results
  assign adder_a   = ctrl.a_sel_pc ? pc : rs1data;
  assign adder_out = adder_a + imm;
  assign pc_plus4  = pc + 32'd4;

  // bit 0 clear only matters for jalr
  assign pc_next = ctrl.jump ? {adder_out[`RV_XLEN-1:1], 1'b0} : pc_plus4;

  always_comb begin
    case (ctrl.wb_sel)
      wb_link: wb_data = pc_plus4;
      wb_load: wb_data = load_data;
      default: wb_data = adder_out;
    endcase
  end

  always_comb begin
    req.read   = ctrl.mem_read && !halt;
    req.write  = ctrl.mem_write && !halt;
    req.funct3 = ctrl.funct3;
    req.addr   = adder_out;
    req.wdata  = rs2data;
  end

  rv_lsu u_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .load_data (load_data),
    .done      (lsu_done),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata)
  );

  // memory ops hold until the response edge
  assign stall  = (ctrl.mem_read || ctrl.mem_write) && !lsu_done;
  assign retire = !halt && !ctrl.ebreak && !stall; // ebreak keeps its pc

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else begin
      if (retire) pc <= pc_next;
      if (ctrl.ebreak) halt <= 1'b1; // sticky until reset
    end
  end

endmodule

// ==== sim/rv_core_props.sv ====
`timescale 1ns/1ps

module rv_core_props (
  input logic               clk,
  input logic               rst_n,
  input rv_core_pkg::word_t pc,
  input logic               halt,
  input logic               awvalid,
  input logic               awready,
  input rv_core_pkg::word_t awaddr,
  input logic               wvalid,
  input logic               wready,
  input rv_core_pkg::word_t wdata,
  input rv_core_pkg::strb_t wstrb,
  input logic               bvalid,
  input logic               bready,
  input logic               arvalid,
  input logic               arready,
  input rv_core_pkg::word_t araddr,
  input logic               rvalid,
  input logic               rready
);
  import rv_core_pkg::*;

  int failures = 0;

  logic pending; // access open and no response this edge
  assign pending = arvalid || awvalid || wvalid || (bready && !bvalid) || (rready && !rvalid);

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin failures++; $error("awvalid or awaddr changed before awready"); end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin failures++; $error("wvalid or write data changed before wready"); end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(araddr))
    else begin failures++; $error("arvalid or araddr changed before arready"); end

  pc_stall: assert property (@(posedge clk) disable iff (!rst_n) pending |=> $stable(pc))
    else begin failures++; $error("pc moved during a pending access"); end

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
    else begin failures++; $error("halt dropped without reset"); end

  strb_set: assert property (@(posedge clk) disable iff (!rst_n) wvalid |-> wstrb != '0)
    else begin failures++; $error("wvalid with an empty strobe"); end

endmodule

bind rv_core_top rv_core_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .pc      (pc),
  .halt    (halt),
  .awvalid (awvalid),
  .awready (awready),
  .awaddr  (awaddr),
  .wvalid  (wvalid),
  .wready  (wready),
  .wdata   (wdata),
  .wstrb   (wstrb),
  .bvalid  (bvalid),
  .bready  (bready),
  .arvalid (arvalid),
  .arready (arready),
  .araddr  (araddr),
  .rvalid  (rvalid),
  .rready  (rready)
);

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module tb_rv_core;
  import rv_core_pkg::*;

  localparam word_t rst_pc         = `RV_RESET_PC;
  localparam word_t base           = 32'h1000_0000; // data area set up by the first lui
  localparam int    timeout_cycles = 200;

  localparam logic [2:0] k_plain = 3'd0;
  localparam logic [2:0] k_store = 3'd1;
  localparam logic [2:0] k_load  = 3'd2;
  localparam logic [2:0] k_skip  = 3'd3; // jumped over and never executed
  localparam logic [2:0] k_halt  = 3'd4;

  // channel indices for probe and drive_slave
  localparam int ch_aw = 0;
  localparam int ch_w  = 1;
  localparam int ch_b  = 2;
  localparam int ch_ar = 3;
  localparam int ch_r  = 4;

  typedef struct packed {
    logic [2:0] kind;
    word_t      inst;
    word_t      addr;    // store or load byte address
    word_t      data;    // expected store data in the strobed lanes
    strb_t      strb;
    word_t      rdata;   // word the slave returns on a load
    word_t      next_pc;
  } row_t;

  logic  clk = 1'b0;
  logic  rst_n;
  word_t inst;
  word_t pc;
  logic  halt;
  logic  awvalid;
  logic  awready;
  word_t awaddr;
  logic  wvalid;
  logic  wready;
  word_t wdata;
  strb_t wstrb;
  logic  bvalid;
  logic  bready;
  logic  arvalid;
  logic  arready;
  word_t araddr;
  logic  rvalid;
  logic  rready;
  word_t rdata;
  row_t  tbl[$];

  always #5 clk = ~clk;

  rv_core_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .halt    (halt),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata)
  );

  // instruction encoders
  function automatic word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t stype(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function automatic word_t utype(input logic [19:0] imm, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t jtype(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b110_1111};
  endfunction

  function automatic word_t row_pc();
    return rst_pc + word_t'(4 * tbl.size());
  endfunction

  function automatic void plain_row(input word_t i);
    tbl.push_back({k_plain, i, 32'h0, 32'h0, 4'h0, 32'h0, row_pc() + 32'd4});
  endfunction

  function automatic void store_row(input word_t i, input word_t a, input word_t d,
                                    input strb_t s);
    tbl.push_back({k_store, i, a, d, s, 32'h0, row_pc() + 32'd4});
  endfunction

  function automatic void load_row(input word_t i, input word_t a, input word_t rd_word);
    tbl.push_back({k_load, i, a, 32'h0, 4'h0, rd_word, row_pc() + 32'd4});
  endfunction

  function automatic void jump_row(input word_t i, input word_t target);
    tbl.push_back({k_plain, i, 32'h0, 32'h0, 4'h0, 32'h0, target});
  endfunction

  function automatic void skip_row();
    tbl.push_back({k_skip, 32'h0000_0013, 32'h0, 32'h0, 4'h0, 32'h0, 32'h0});
  endfunction

  function automatic void halt_row();
    tbl.push_back({k_halt, 32'h0010_0073, 32'h0, 32'h0, 4'h0, 32'h0, row_pc()});
  endfunction

  function automatic void build_program();
    plain_row(utype(20'h10000, 5'd1, op_lui));                         // x1 = base
    plain_row(itype(12'h123, 5'd0, 3'b000, 5'd2, op_imm));
    store_row(stype(12'd0, 5'd2, 5'd1, 3'b010), base, 32'h0000_0123, 4'b1111);
    plain_row(itype(12'hFFB, 5'd2, 3'b000, 5'd3, op_imm));             // 0x123 - 5
    store_row(stype(12'd4, 5'd3, 5'd1, 3'b010), base + 32'h04, 32'h0000_011E, 4'b1111);
    plain_row(utype(20'hABCDE, 5'd4, op_lui));
    store_row(stype(12'd8, 5'd4, 5'd1, 3'b010), base + 32'h08, 32'hABCD_E000, 4'b1111);
    plain_row(utype(20'h00001, 5'd5, op_auipc));                       // pc 0x1C + 0x1000
    store_row(stype(12'd12, 5'd5, 5'd1, 3'b010), base + 32'h0C, rst_pc + 32'h101C, 4'b1111);
    plain_row(utype(20'h12345, 5'd6, op_lui));
    plain_row(itype(12'h678, 5'd6, 3'b000, 5'd6, op_imm));
    store_row(stype(12'd16, 5'd6, 5'd1, 3'b000), base + 32'h10, 32'h0000_0078, 4'b0001);
    store_row(stype(12'd17, 5'd6, 5'd1, 3'b000), base + 32'h11, 32'h0000_7800, 4'b0010);
    store_row(stype(12'd18, 5'd6, 5'd1, 3'b000), base + 32'h12, 32'h0078_0000, 4'b0100);
    store_row(stype(12'd19, 5'd6, 5'd1, 3'b000), base + 32'h13, 32'h7800_0000, 4'b1000);
    store_row(stype(12'd20, 5'd6, 5'd1, 3'b001), base + 32'h14, 32'h0000_5678, 4'b0011);
    store_row(stype(12'd22, 5'd6, 5'd1, 3'b001), base + 32'h16, 32'h5678_0000, 4'b1100);
    load_row(itype(12'd1, 5'd1, 3'b000, 5'd7, op_load), base + 32'h01, 32'hA1B2_C3D4);
    store_row(stype(12'd24, 5'd7, 5'd1, 3'b010), base + 32'h18, 32'hFFFF_FFC3, 4'b1111);
    load_row(itype(12'd2, 5'd1, 3'b100, 5'd8, op_load), base + 32'h02, 32'hA1B2_C3D4);
    store_row(stype(12'd28, 5'd8, 5'd1, 3'b010), base + 32'h1C, 32'h0000_00B2, 4'b1111);
    load_row(itype(12'd2, 5'd1, 3'b001, 5'd9, op_load), base + 32'h02, 32'h8765_4321);
    store_row(stype(12'd32, 5'd9, 5'd1, 3'b010), base + 32'h20, 32'hFFFF_8765, 4'b1111);
    load_row(itype(12'd0, 5'd1, 3'b101, 5'd10, op_load), base, 32'h1234_F00D);
    store_row(stype(12'd36, 5'd10, 5'd1, 3'b010), base + 32'h24, 32'h0000_F00D, 4'b1111);
    load_row(itype(12'd8, 5'd1, 3'b010, 5'd11, op_load), base + 32'h08, 32'hCAFE_BABE);
    store_row(stype(12'd40, 5'd11, 5'd1, 3'b010), base + 32'h28, 32'hCAFE_BABE, 4'b1111);
    jump_row(jtype(21'd8, 5'd12), rst_pc + 32'h74);                     // jal from 0x6C
    skip_row();
    store_row(stype(12'd44, 5'd12, 5'd1, 3'b010), base + 32'h2C, rst_pc + 32'h70, 4'b1111);
    plain_row(utype(20'h00000, 5'd13, op_auipc));                      // x13 = pc 0x78
    jump_row(itype(12'd17, 5'd13, 3'b000, 5'd14, op_jalr), rst_pc + 32'h88); // odd target
    skip_row();
    skip_row();
    store_row(stype(12'd48, 5'd14, 5'd1, 3'b010), base + 32'h30, rst_pc + 32'h80, 4'b1111);
    halt_row();
  endfunction

  function automatic word_t lane_mask(input strb_t s);
    word_t m;
    m = '0;
    for (int i = 0; i < 4; i++) m[8*i +: 8] = {8{s[i]}};
    return m;
  endfunction

  function automatic logic probe(input int ch);
    case (ch)
      ch_aw:   return awvalid;
      ch_w:    return wvalid;
      ch_b:    return bready;
      ch_ar:   return arvalid;
      default: return rready;
    endcase
  endfunction

  task automatic drive_slave(input int ch, input logic v);
    case (ch)
      ch_aw:   awready = v;
      ch_w:    wready  = v;
      ch_b:    bvalid  = v;
      ch_ar:   arready = v;
      default: rvalid  = v;
    endcase
  endtask

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic bad_value(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "value mismatch");
  endtask

  // returns at a falling edge with the master side of ch high
  task automatic wait_high(input int ch, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!probe(ch)) begin
      n++;
      if (n > timeout_cycles) stop_run($sformatf("timed out waiting for %s", what));
      @(negedge clk);
    end
  endtask

  // raise the slave side after a random wait and hold it through the accepting edge
  task automatic handshake(input int ch, input string what);
    int unsigned delay;
    delay = $urandom_range(3, 0);
    repeat (delay + 1) @(posedge clk);
    #1;
    drive_slave(ch, 1'b1);
    wait_high(ch, what);
    @(posedge clk);
    #1;
    drive_slave(ch, 1'b0);
  endtask

  task automatic serve_store(input row_t r);
    wait_high(ch_aw, "awvalid");
    assert (wvalid) else bad_value("wvalid did not rise together with awvalid");
    assert (awaddr == r.addr)
      else bad_value($sformatf("awaddr %h, expected %h", awaddr, r.addr));
    assert (wstrb == r.strb)
      else bad_value($sformatf("wstrb %b at %h, expected %b", wstrb, r.addr, r.strb));
    assert ((wdata & lane_mask(r.strb)) == r.data)
      else bad_value($sformatf("wdata %h at %h, expected %h", wdata, r.addr, r.data));
    // aw and w accepted in either order or on the same edge
    fork
      handshake(ch_aw, "awvalid");
      handshake(ch_w, "wvalid");
    join
    handshake(ch_b, "bready");
  endtask

  task automatic serve_load(input row_t r);
    wait_high(ch_ar, "arvalid");
    assert (araddr == r.addr)
      else bad_value($sformatf("araddr %h, expected %h", araddr, r.addr));
    handshake(ch_ar, "arvalid");
    rdata = r.rdata;
    handshake(ch_r, "rready");
  endtask

  task automatic check_halt(input row_t r);
    @(posedge clk);
    #1;
    assert (halt) else bad_value("halt did not rise after ebreak");
    repeat (20) begin
      @(negedge clk);
      assert (halt && pc == r.next_pc)
        else bad_value($sformatf("after halt pc %h, halt %b", pc, halt));
      assert (!(awvalid || wvalid || arvalid)) else bad_value("valid raised while halted");
    end
  endtask

  // bound protocol checks count their failures
  always @(negedge clk) begin
    if (UUT.u_props.failures != 0) stop_run("a bound protocol assertion failed");
  end

  initial begin
    row_t  r;
    word_t ofs;
    int    idx;
    int    steps;
    bit    finished;
    void'($urandom(32'h6185));
    rst_n   = 1'b0;
    inst    = 32'h0000_0013; // nop during reset
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    build_program();
    repeat (15) @(posedge clk);
    @(negedge clk);
    assert (pc == rst_pc) else bad_value($sformatf("reset pc %h, expected %h", pc, rst_pc));
    assert (!halt) else bad_value("halt high after reset");
    assert (!(awvalid || wvalid || arvalid)) else bad_value("valid high during reset");
    @(posedge clk);
    #1;
    rst_n    = 1'b1;
    steps    = 0;
    finished = 1'b0;
    while (!finished) begin
      ofs = pc - rst_pc;
      idx = int'(ofs >> 2);
      if (ofs[1:0] != 2'b00 || idx < 0 || idx >= tbl.size()) begin
        stop_run("pc left the instruction table");
      end
      steps++;
      if (steps > tbl.size()) stop_run("program never reached ebreak");
      r    = tbl[idx];
      inst = r.inst;
      case (r.kind)
        k_store: serve_store(r);
        k_load:  serve_load(r);
        k_skip:  stop_run("executed an instruction that a jump should skip");
        k_halt: begin
          check_halt(r);
          finished = 1'b1;
        end
        default: begin
          @(posedge clk);
          #1;
        end
      endcase
      assert (pc == r.next_pc)
        else bad_value($sformatf("pc %h after row %0d, expected %h", pc, idx, r.next_pc));
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_lsu.sv
src/rv_core_top.sv
sim/rv_core_props.sv
sim/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_rv_core \
  -f list.f \
  -o sim_rv_core \
  && ./obj_dir/sim_rv_core +verilator+error+limit+100 \
  || exit $?
